// ==== rtl/io_settings.svh ====
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

`default_nettype none

// --------------------
// timing

// clock cycles per ms tick
// real board would use clock_freq / 1000
`define IO_TICK_DIV 40
`define IO_RST_CYCLES 4         // length of device restart in cycles

// --------------------
// IO window byte addresses
// window is FFFF00 to FFFFFF

`define IO_ADDR_TMR 24'hFFFFC0  // -64
`define IO_ADDR_WD  24'hFFFF90  // -112
`define IO_ADDR_STM 24'hFFFFA0  // -96 and three more words up to -84
`define IO_ADDR_SCS 24'hFFFFB8  // -72 and -68

`default_nettype wire

`endif

// ==== rtl/io_pkg.sv ====
`default_nettype none

package io_pkg;

  // device picked by the current bus address
  typedef enum logic [2:0] {
    DEV_NONE = 3'd0,    // outside window or unmapped slot
    DEV_TMR  = 3'd1,    // ms timer
    DEV_WD   = 3'd2,    // watchdog
    DEV_STM  = 3'd3,    // stack monitor
    DEV_SCS  = 3'd4     // sys control and status
  } io_dev_e;

  // error lines into sys control
  // order matches the cause bits read back by software
  typedef struct packed {
    logic hot;          // bit 2 is stack hot zone
    logic lim;          // bit 1 is stack limit
    logic wd;           // bit 0 is watchdog
  } err_sig_t;

endpackage

`default_nettype wire

// ==== rtl/io_decode.sv ====
`timescale 1ns/1ns
`include "io_settings.svh"
`default_nettype none

module io_decode import io_pkg::*; (
  input  logic [23:0] addr,
  input  logic        rd,
  input  logic [31:0] tmr_dout,
  input  logic [31:0] wd_dout,
  input  logic [31:0] stm_dout,
  input  logic [31:0] scs_dout,
  output logic        tmr_stb,
  output logic        wd_stb,
  output logic        stm_stb,
  output logic        scs_stb,
  output logic [31:0] data_out
);

  localparam logic [23:0] TMR_A = `IO_ADDR_TMR;
  localparam logic [23:0] WD_A  = `IO_ADDR_WD;
  localparam logic [23:0] STM_A = `IO_ADDR_STM;
  localparam logic [23:0] SCS_A = `IO_ADDR_SCS;

  logic    io_en;     // addr inside the 256 byte window
  logic    hit_tmr;   // raw slot matches, before priority
  logic    hit_wd;
  logic    hit_stm;
  logic    hit_scs;
  io_dev_e dev;

  // --------------------
  // address decode
  assign io_en   = (addr[23:8] == TMR_A[23:8]);
  assign hit_tmr = io_en && (addr[7:2] == TMR_A[7:2]);   // single word
  assign hit_wd  = io_en && (addr[7:2] == WD_A[7:2]);    // single word
  assign hit_stm = io_en && (addr[7:4] == STM_A[7:4]);   // four words
  assign hit_scs = io_en && (addr[7:3] == SCS_A[7:3]);   // two words

  always_comb begin
    dev = DEV_NONE;
    if (hit_tmr)      dev = DEV_TMR;
    else if (hit_wd)  dev = DEV_WD;
    else if (hit_stm) dev = DEV_STM;
    else if (hit_scs) dev = DEV_SCS;
  end

  assign tmr_stb = (dev == DEV_TMR);
  assign wd_stb  = (dev == DEV_WD);
  assign stm_stb = (dev == DEV_STM);
  assign scs_stb = (dev == DEV_SCS);

  // --------------------
  // read data mux, zero when idle or unmapped
  always_comb begin
    data_out = 32'h0;
    if (rd) begin
      case (dev)
        DEV_TMR: data_out = tmr_dout;
        DEV_WD:  data_out = wd_dout;
        DEV_STM: data_out = stm_dout;
        DEV_SCS: data_out = scs_dout;
        default: data_out = 32'h0;
      endcase
    end
  end

  // device slots must not overlap, so only one device sees the bus
  always_comb begin
    a_stb_onehot: assert ($onehot0({hit_tmr, hit_wd, hit_stm, hit_scs}))
      else $error("io_decode: address matches more than one device");
  end

endmodule

`default_nettype wire

// ==== rtl/ms_timer.sv ====
`timescale 1ns/1ns
`include "io_settings.svh"
`default_nettype none

module ms_timer import io_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        dev_rst,       // restart from sys control
  input  logic        stb,
  output logic [31:0] data_out,
  output logic        ms_tick        // one cycle per ms
);

  localparam int PW = $clog2(`IO_TICK_DIV);
  localparam logic [PW-1:0] PRESC_MAX = PW'(`IO_TICK_DIV - 1);

  logic [PW-1:0] presc;              // cycle prescaler
  logic [31:0]   ms_cnt;             // ms since reset

  // --------------------
  // prescaler and tick
  always_ff @(posedge clk) begin
    if (rst || dev_rst) begin
      presc <= '0;
      ms_tick <= 1'b0;
    end else if (presc == PRESC_MAX) begin
      presc <= '0;
      ms_tick <= 1'b1;               // first tick IO_TICK_DIV cycles after reset
    end else begin
      presc <= presc + PW'(1);
      ms_tick <= 1'b0;
    end
  end

  // --------------------
  // running ms counter
  always_ff @(posedge clk) begin
    if (rst || dev_rst) begin
      ms_cnt <= 32'h0;
    end else if (ms_tick) begin
      ms_cnt <= ms_cnt + 32'd1;      // wraps after ~49 days
    end
  end

  // read-only, writes are ignored
  assign data_out = stb ? ms_cnt : 32'h0;

endmodule

`default_nettype wire

// ==== rtl/watchdog.sv ====
`timescale 1ns/1ns
`default_nettype none

module watchdog import io_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        dev_rst,
  input  logic        stb,
  input  logic        wr,
  input  logic [15:0] data_in,       // timeout in ms, zero disables
  input  logic        ms_tick,
  output logic [31:0] data_out,
  output logic        trig
);

  logic [15:0] timeout;              // as last written
  logic [15:0] count;                // ms remaining
  logic        en;

  assign en = (timeout != 16'h0);

  // --------------------
  // timeout counter
  always_ff @(posedge clk) begin
    if (rst || dev_rst) begin
      timeout <= 16'h0;
      count <= 16'h0;
      trig <= 1'b0;
    end else if (stb && wr) begin
      // reload, also the normal way to feed the dog
      timeout <= data_in;
      count <= data_in;
      trig <= 1'b0;
    end else if (ms_tick && en && (count != 16'h0)) begin
      count <= count - 16'd1;
      if (count == 16'd1) begin
        trig <= 1'b1;                // rises on the edge where count hits zero
      end
    end
  end

  // remaining count high, timeout low
  assign data_out = stb ? {count, timeout} : 32'h0;

  // --------------------
  // a disabled watchdog never holds a trigger
  a_no_trig_disabled: assert property (
    @(posedge clk) disable iff (rst)
    trig |-> en
  ) else $error("watchdog: trig high while disabled");

endmodule

`default_nettype wire

// ==== rtl/stack_mon.sv ====
`timescale 1ns/1ns
`default_nettype none

module stack_mon import io_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        dev_rst,
  input  logic        stb,
  input  logic        wr,
  input  logic [1:0]  reg_sel,       // addr[3:2]
  input  logic [23:0] data_in,
  input  logic [23:0] sp_in,         // CPU stack pointer
  output logic [31:0] data_out,
  output logic        trig_lim,
  output logic        trig_hot
);

  localparam logic [1:0] SEL_LIM  = 2'd0;
  localparam logic [1:0] SEL_HOT  = 2'd1;
  localparam logic [1:0] SEL_LOW  = 2'd2;
  localparam logic [1:0] SEL_STAT = 2'd3;

  logic [23:0] limit;                // stack limit, zero is off
  logic [23:0] hot;                  // hot zone address, zero is off
  logic [23:0] lowest;               // lowest sp seen, ie. stack usage
  logic        wr_en;

  assign wr_en = stb && wr;

  // --------------------
  // config registers
  always_ff @(posedge clk) begin
    if (rst || dev_rst) begin
      limit <= 24'h0;
      hot <= 24'h0;
    end else if (wr_en) begin
      if (reg_sel == SEL_LIM) limit <= data_in;
      if (reg_sel == SEL_HOT) hot <= data_in;
      // status is read-only
    end
  end

  // --------------------
  // lowest address tracking
  always_ff @(posedge clk) begin
    if (rst || dev_rst) begin
      lowest <= 24'hFFFFFF;
    end else if (wr_en && (reg_sel == SEL_LOW)) begin
      lowest <= 24'hFFFFFF;          // restart tracking, data ignored
    end else if (sp_in < lowest) begin
      lowest <= sp_in;
    end
  end

  // --------------------
  // triggers, one cycle behind sp_in
  always_ff @(posedge clk) begin
    if (rst || dev_rst) begin
      trig_lim <= 1'b0;
      trig_hot <= 1'b0;
    end else begin
      trig_lim <= (limit != 24'h0) && (sp_in < limit);
      trig_hot <= (hot != 24'h0) && (sp_in < hot);
    end
  end

  // --------------------
  // readback
  always_comb begin
    data_out = 32'h0;
    if (stb) begin
      case (reg_sel)
        SEL_LIM:  data_out = {8'h0, limit};
        SEL_HOT:  data_out = {8'h0, hot};
        SEL_LOW:  data_out = {8'h0, lowest};
        SEL_STAT: data_out = {30'h0, trig_hot, trig_lim};
        default:  data_out = 32'h0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sys_ctrl.sv ====
`timescale 1ns/1ns
`include "io_settings.svh"
`default_nettype none

module sys_ctrl import io_pkg::*; (
  input  logic        clk,
  input  logic        rst,           // no dev_rst here, must survive restart
  input  logic        stb,
  input  logic        wr,
  input  logic        reg_sel,       // addr[2]
  input  logic [1:1]  data_in,       // clear bit
  input  err_sig_t    err_sig,
  input  logic [21:0] pc_in,         // word address
  output logic [31:0] data_out,
  output logic        dev_rst,
  output logic        err_out
);

  localparam int CW = $clog2(`IO_RST_CYCLES + 1);
  localparam logic [CW-1:0] RST_LEN = CW'(`IO_RST_CYCLES);

  logic          err_latched;        // first error seen
  err_sig_t      cause;
  logic [23:0]   err_addr;           // byte address of the failing code
  logic [CW-1:0] rst_cnt;            // restart cycles still to go
  logic          new_err;
  logic          clr;

  assign new_err = (err_sig != 3'b000) && !err_latched;
  assign clr = stb && wr && !reg_sel && data_in[1];

  // --------------------
  // error latch and capture
  always_ff @(posedge clk) begin
    if (rst) begin
      err_latched <= 1'b0;
      cause <= '0;
    end else if (clr) begin
      err_latched <= 1'b0;           // cause kept for post mortem
    end else if (new_err) begin
      err_latched <= 1'b1;
      cause <= err_sig;
    end
  end

  always_ff @(posedge clk) begin
    if (new_err && !clr) begin
      err_addr <= {pc_in, 2'b00};
    end
  end

  // --------------------
  // timed device restart, starts the edge after the latch
  always_ff @(posedge clk) begin
    if (rst) begin
      rst_cnt <= '0;
      dev_rst <= 1'b0;
    end else begin
      dev_rst <= (rst_cnt != '0);
      if (new_err && !clr) rst_cnt <= RST_LEN;
      else if (rst_cnt != '0) rst_cnt <= rst_cnt - CW'(1);
    end
  end

  assign err_out = err_latched;

  // reg 0 flag plus cause, reg 1 error address
  assign data_out = !stb    ? 32'h0 :
                    reg_sel ? {8'h0, err_addr} :
                              {28'h0, cause, err_latched};

  a_dev_rst_len: assert property (
    @(posedge clk) disable iff (rst)
    $rose(dev_rst) |-> ##[1:`IO_RST_CYCLES] !dev_rst
  ) else $error("sys_ctrl: dev_rst held too long");

endmodule

`default_nettype wire

// ==== rtl/io_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module io_top import io_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [23:0] addr,          // byte address
  input  logic        rd,
  input  logic        wr,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  input  logic [23:0] sp_in,         // CPU stack pointer
  input  logic [21:0] pc_in,         // CPU pc, word address
  output logic        dev_rst,
  output logic        err_out
);

  // ms timer
  logic        tmr_stb;
  logic [31:0] tmr_dout;
  logic        ms_tick;
  // watchdog
  logic        wd_stb;
  logic [31:0] wd_dout;
  logic        wd_trig;
  // stack monitor
  logic        stm_stb;
  logic [31:0] stm_dout;
  logic        stm_trig_lim;
  logic        stm_trig_hot;
  // sys control
  logic        scs_stb;
  logic [31:0] scs_dout;
  err_sig_t    err_sig;

  // --------------------
  // decode and read mux
  io_decode io_decode_0 (
    .addr(addr), .rd(rd),
    .tmr_dout(tmr_dout), .wd_dout(wd_dout),
    .stm_dout(stm_dout), .scs_dout(scs_dout),
    .tmr_stb(tmr_stb), .wd_stb(wd_stb),
    .stm_stb(stm_stb), .scs_stb(scs_stb),
    .data_out(data_out)
  );

  // --------------------
  // devices
  ms_timer tmr_0 (
    .clk(clk), .rst(rst), .dev_rst(dev_rst), .stb(tmr_stb),
    .data_out(tmr_dout), .ms_tick(ms_tick)
  );

  watchdog watchdog_0 (
    .clk(clk), .rst(rst), .dev_rst(dev_rst), .stb(wd_stb), .wr(wr),
    .data_in(data_in[15:0]), .ms_tick(ms_tick),
    .data_out(wd_dout), .trig(wd_trig)
  );

  stack_mon stack_mon_0 (
    .clk(clk), .rst(rst), .dev_rst(dev_rst), .stb(stm_stb), .wr(wr),
    .reg_sel(addr[3:2]), .data_in(data_in[23:0]), .sp_in(sp_in),
    .data_out(stm_dout), .trig_lim(stm_trig_lim), .trig_hot(stm_trig_hot)
  );

  // bit order must match err_sig_t
  assign err_sig = {stm_trig_hot, stm_trig_lim, wd_trig};

  sys_ctrl sys_ctrl_0 (
    .clk(clk), .rst(rst), .stb(scs_stb), .wr(wr),
    .reg_sel(addr[2]), .data_in(data_in[1:1]),
    .err_sig(err_sig), .pc_in(pc_in),
    .data_out(scs_dout), .dev_rst(dev_rst), .err_out(err_out)
  );

endmodule

`default_nettype wire

// ==== verif/io_tb_tasks.svh ====
`ifndef IO_TB_TASKS_SVH
`define IO_TB_TASKS_SVH

`default_nettype none

// --------------------
// reference model state
logic [23:0] model_low;              // lowest sp driven since the last restart
logic [21:0] model_pc;               // pc held when the error latches
int          n_checks = 0;
int          n_errors = 0;

// --------------------
// bus cycles, strobes held for one cycle
task automatic bus_write(input logic [23:0] a, input logic [31:0] d);
  @(negedge clk);
  addr = a;
  data_in = d;
  wr = 1'b1;
  @(negedge clk);                    // write edge has passed
  wr = 1'b0;
  addr = 24'h0;
endtask

task automatic bus_read(input logic [23:0] a, output logic [31:0] d);
  @(negedge clk);
  addr = a;
  rd = 1'b1;
  #2;                                // mid low phase, comb read settled
  d = data_out;
  @(negedge clk);
  rd = 1'b0;
  addr = 24'h0;
endtask

// --------------------
// checks
task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                           input string what);
  n_checks++;
  a_value: assert (got == want)
    else begin
      n_errors++;
      $display("mismatch at %0t ns: %s, got %h want %h", $time, what, got, want);
    end
endtask

task automatic check_range(input int got, input int lo, input int hi, input string what);
  n_checks++;
  a_range: assert (got >= lo && got <= hi)
    else begin
      n_errors++;
      $display("mismatch at %0t ns: %s, got %0d allowed %0d to %0d",
               $time, what, got, lo, hi);
    end
endtask

task automatic report_failure(input string what);
  n_errors++;
  $display("error at %0t ns: %s", $time, what);
endtask

// bounded wait for dev_rst to reach a level
task automatic wait_dev_rst(input logic level, input int max_cyc, output int cyc);
  cyc = 0;
  while (dev_rst !== level && cyc < max_cyc) begin
    @(negedge clk);
    cyc++;
  end
  if (dev_rst !== level) begin
    report_failure($sformatf("dev_rst did not go to %b within %0d cycles", level, max_cyc));
  end
endtask

`default_nettype wire

`endif

// ==== verif/io_top_tb.sv ====
`timescale 1ns/1ns
`include "io_settings.svh"
`default_nettype none

module io_top_tb;

  localparam logic [23:0] SP_IDLE = 24'hFFFFF0;  // above every limit used
  localparam logic [23:0] A_LIM  = `IO_ADDR_STM;
  localparam logic [23:0] A_HOT  = `IO_ADDR_STM + 24'h4;
  localparam logic [23:0] A_LOW  = `IO_ADDR_STM + 24'h8;
  localparam logic [23:0] A_STAT = `IO_ADDR_STM + 24'hC;
  localparam logic [23:0] A_SCS0 = `IO_ADDR_SCS;
  localparam logic [23:0] A_SCS1 = `IO_ADDR_SCS + 24'h4;
  localparam int TMR_MS = 5;                      // ms between timer reads
  // cycle budget: reset, decode, timer, stack, watchdog, restart
  localparam int RUN_CYCLES = 16 + 30 + (TMR_MS * `IO_TICK_DIV + 10) + 50 +
                              (8 * `IO_TICK_DIV + 30) + 40;
  localparam int LIMIT_NS = (RUN_CYCLES + 300) * 8;

  logic        clk = 1'b0;
  logic        rst;
  logic [23:0] addr;
  logic        rd;
  logic        wr;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic [23:0] sp_in;
  logic [21:0] pc_in;
  logic        dev_rst;
  logic        err_out;
  int          n_tests = 0;
  int          err_base = 0;

  `include "io_tb_tasks.svh"

  io_top io_top_inst (
    .clk(clk), .rst(rst), .addr(addr), .rd(rd), .wr(wr),
    .data_in(data_in), .data_out(data_out), .sp_in(sp_in), .pc_in(pc_in),
    .dev_rst(dev_rst), .err_out(err_out)
  );

  always #4 clk = ~clk;              // 8 ns period

  // outputs quiet straight after a reset edge
  a_rst_quiet: assert property (@(posedge clk) rst |=> (!dev_rst && !err_out))
    else begin
      n_errors++;
      $display("error at %0t ns: dev_rst or err_out high after reset", $time);
    end

  task automatic begin_test();
    err_base = n_errors;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %0d %s: %0d errors", n_tests, name, n_errors - err_base);
  endtask

  // --------------------
  // run limit
  initial begin
    #(LIMIT_NS);
    $display("timeout: run did not finish within %0d ns", LIMIT_NS);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [31:0] v;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [23:0] lim_val;
    logic [23:0] hot_val;
    logic [23:0] sp_low;
    logic [15:0] wd_val;
    int          t_ms;
    int          cyc;
    int          hi_cyc;
    void'($urandom(14020));
    rst = 1'b1;
    addr = 24'h0;
    rd = 1'b0;
    wr = 1'b0;
    data_in = 32'h0;
    sp_in = SP_IDLE;
    pc_in = 22'h0;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    // --------------------
    // decode and readback
    begin_test();
    bus_read(24'h001000, v);
    check_value(v, 32'h0, "read outside IO window");
    bus_read(24'hFFFF00, v);
    check_value(v, 32'h0, "read of unmapped IO slot");
    lim_val = {1'b0, 23'($urandom)} | 24'h1;   // below SP_IDLE, nonzero
    hot_val = {1'b0, 23'($urandom)} | 24'h1;
    bus_write(A_LIM, {8'h0, lim_val});
    bus_write(A_HOT, {8'h0, hot_val});
    bus_read(A_LIM, v);
    check_value(v, {8'h0, lim_val}, "stack limit readback");
    bus_read(A_HOT, v);
    check_value(v, {8'h0, hot_val}, "hot zone readback");
    bus_write(A_LIM, 32'h0);
    bus_write(A_HOT, 32'h0);
    wd_val = 16'($urandom) | 16'h0100;   // long timeout, cannot fire here
    bus_write(`IO_ADDR_WD, {16'h0, wd_val});
    bus_read(`IO_ADDR_WD, v);
    check_value({16'h0, v[15:0]}, {16'h0, wd_val}, "watchdog timeout readback");
    bus_write(`IO_ADDR_WD, 32'h0);   // watchdog off again
    end_test("decode");

    // --------------------
    // ms timer
    begin_test();
    bus_read(`IO_ADDR_TMR, t0);
    repeat (TMR_MS * `IO_TICK_DIV - 2) @(negedge clk);   // reads add two cycles
    bus_read(`IO_ADDR_TMR, t1);
    check_range(int'(t1 - t0), TMR_MS - 1, TMR_MS + 1, "timer delta in ms");
    end_test("ms timer");

    // --------------------
    // stack monitor, tracking then limit trigger
    begin_test();
    bus_write(A_LOW, 32'h0);         // restart tracking
    model_low = sp_in;               // idle sp sampled on the next edge
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      sp_in = 24'($urandom);
      if (sp_in < model_low) model_low = sp_in;
    end
    bus_read(A_LOW, v);
    check_value(v, {8'h0, model_low}, "lowest sp");
    @(negedge clk);
    sp_in = SP_IDLE;
    lim_val = 24'h400000 + 24'($urandom % 32'h300000);
    sp_low = lim_val - 24'h1 - 24'($urandom % 32'h1000);
    bus_write(A_LIM, {8'h0, lim_val});
    check_value({31'h0, err_out}, 32'h0, "err_out before limit hit");
    @(negedge clk);
    sp_in = sp_low;
    bus_read(A_STAT, v);             // trig_lim registered one cycle later
    check_value(v, 32'h1, "stack status");
    check_value({31'h0, err_out}, 32'h1, "err_out after limit hit");
    sp_in = SP_IDLE;
    bus_read(A_SCS0, v);
    check_value(v, 32'h5, "cause after limit hit");  // lim bit plus latch
    wait_dev_rst(1'b0, 2 * `IO_RST_CYCLES + 4, cyc);
    bus_write(A_SCS0, 32'h2);
    check_value({31'h0, err_out}, 32'h0, "err_out after clear");
    end_test("stack monitor");

    // --------------------
    // watchdog timeout
    begin_test();
    t_ms = 3 + int'($urandom % 4);
    bus_write(`IO_ADDR_WD, 32'(t_ms));
    cyc = 0;
    while (!err_out && cyc < (t_ms + 2) * `IO_TICK_DIV) begin
      @(negedge clk);
      cyc++;
    end
    if (!err_out) begin
      report_failure("watchdog never raised err_out");
    end else begin
      check_range(cyc, (t_ms - 1) * `IO_TICK_DIV, (t_ms + 1) * `IO_TICK_DIV,
                  "cycles to watchdog error");
    end
    bus_read(A_SCS0, v);
    check_value(v, 32'h3, "cause after watchdog");   // wd bit plus latch
    wait_dev_rst(1'b0, 2 * `IO_RST_CYCLES + 4, cyc);
    bus_write(A_SCS0, 32'h2);
    end_test("watchdog");

    // --------------------
    // error capture and timed restart
    begin_test();
    hot_val = 24'h400000 + 24'($urandom % 32'h300000);
    bus_write(A_HOT, {8'h0, hot_val});
    @(negedge clk);
    pc_in = 22'($urandom);
    model_pc = pc_in;
    sp_in = hot_val - 24'h1 - 24'($urandom % 32'h1000);
    wait_dev_rst(1'b1, 8, cyc);
    sp_in = SP_IDLE;
    pc_in = ~model_pc;               // cpu moved on, capture must hold
    wait_dev_rst(1'b0, 2 * `IO_RST_CYCLES + 4, hi_cyc);
    check_value(32'(hi_cyc), 32'(`IO_RST_CYCLES), "dev_rst length in cycles");
    bus_read(`IO_ADDR_TMR, v);
    check_range(int'(v), 0, 1, "timer after restart");
    bus_read(A_SCS1, v);
    check_value(v, 32'(model_pc) * 32'd4, "error byte address");
    bus_read(A_SCS0, v);
    check_value(v, 32'h9, "cause after hot zone hit");
    bus_write(A_SCS0, 32'h2);
    check_value({31'h0, err_out}, 32'h0, "err_out after clear");
    end_test("error restart");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+rtl
+incdir+verif
rtl/io_pkg.sv
rtl/io_decode.sv
rtl/ms_timer.sv
rtl/watchdog.sv
rtl/stack_mon.sv
rtl/sys_ctrl.sv
rtl/io_top.sv
verif/io_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the io block testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=io_top_tb
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

# compile, assertions on, timing for the testbench delays
verilator --binary --timing --assert -j 0 --top-module "$TOP" -f build.f -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# pass only when the testbench printed its pass line
if grep -qx "Result: PASSED" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
